//--- filelist.f
hdl/rob_pkg.sv
hdl/rob_entry.sv
hdl/rob_alloc_select.sv
hdl/rob_commit.sv
hdl/rob.sv
verification/rob_tb.sv

//--- hdl/rob.sv
/*
 * two-wide reorder buffer, top level
 * entry array, tail pointer, completion decode for the six fus,
 * allocation at the tail and in-order commit with flush
 */
`timescale 1ns/1ps

module rob #(
	parameter  int ROB_SIZE = 16,
	parameter  int PRN_W    = rob_pkg::PRN_W,
	localparam int IDX_W    = $clog2(ROB_SIZE),
	localparam int CNT_W    = $clog2(ROB_SIZE + 1)
) (
	input  logic                                  clock,
	input  logic                                  rst_n,
	// dispatch, lane 1 is older
	input  logic                                  inst1_valid,
	input  rob_pkg::pc_t                          inst1_pc,
	input  rob_pkg::arn_t                         inst1_arn,
	input  logic [PRN_W-1:0]                      inst1_prn,
	input  logic                                  inst1_is_branch,
	input  logic                                  inst2_valid,
	input  rob_pkg::pc_t                          inst2_pc,
	input  rob_pkg::arn_t                         inst2_arn,
	input  logic [PRN_W-1:0]                      inst2_prn,
	input  logic                                  inst2_is_branch,
	output logic [IDX_W-1:0]                      inst1_rob_idx,	// same cycle answer
	output logic [IDX_W-1:0]                      inst2_rob_idx,
	// completion, one report per fu
	input  logic [rob_pkg::NUM_FU-1:0]            fu_done,
	input  logic [rob_pkg::NUM_FU-1:0][IDX_W-1:0] fu_rob_idx,
	input  logic [rob_pkg::NUM_FU-1:0]            fu_mispredict,
	// commit records
	output logic                                  commit1_valid,
	output rob_pkg::pc_t                          commit1_pc,
	output rob_pkg::arn_t                         commit1_arn,
	output logic [PRN_W-1:0]                      commit1_prn,
	output logic                                  commit1_is_branch,
	output logic                                  commit1_mispredict,
	output logic                                  commit2_valid,
	output rob_pkg::pc_t                          commit2_pc,
	output rob_pkg::arn_t                         commit2_arn,
	output logic [PRN_W-1:0]                      commit2_prn,
	output logic                                  commit2_is_branch,
	output logic                                  commit2_mispredict,
	output logic                                  flush,
	output logic [CNT_W-1:0]                      credit_return	// freed slots, back to dispatch
);

	logic [IDX_W-1:0]              tail;
	logic [IDX_W-1:0]              head;
	logic [1:0]                    alloc_count;
	logic [ROB_SIZE-1:0]           load1_vec;
	logic [ROB_SIZE-1:0]           load2_vec;
	logic [ROB_SIZE-1:0]           slot_complete;
	logic [ROB_SIZE-1:0]           slot_mispredict;
	logic [ROB_SIZE-1:0]           clear_vec;
	logic [ROB_SIZE-1:0]           entry_live;
	logic [ROB_SIZE-1:0]           entry_done;
	logic [ROB_SIZE-1:0]           entry_mispredict;
	logic [ROB_SIZE-1:0]           entry_is_branch;
	rob_pkg::pc_t  [ROB_SIZE-1:0]  entry_pc;
	rob_pkg::arn_t [ROB_SIZE-1:0]  entry_arn;
	logic [ROB_SIZE-1:0][PRN_W-1:0] entry_prn;
	logic [CNT_W-1:0]              occupancy;	// live slots

	rob_alloc_select #(.ROB_SIZE(ROB_SIZE)) alloc_i (
		.tail          (tail),
		.inst1_valid   (inst1_valid),
		.inst2_valid   (inst2_valid),
		.load1_vec     (load1_vec),
		.load2_vec     (load2_vec),
		.inst1_rob_idx (inst1_rob_idx),
		.inst2_rob_idx (inst2_rob_idx),
		.alloc_count   (alloc_count)
	);

	// fu reports to per-slot strobes, any unit may name any slot
	always_comb begin
		slot_complete   = '0;
		slot_mispredict = '0;
		for (int s = 0; s < ROB_SIZE; s++) begin
			for (int f = 0; f < rob_pkg::NUM_FU; f++) begin
				if (fu_done[f] && (fu_rob_idx[f] == IDX_W'(s))) begin
					slot_complete[s]   = 1'b1;
					slot_mispredict[s] = slot_mispredict[s] | fu_mispredict[f];
				end
			end
		end
	end

	for (genvar s = 0; s < ROB_SIZE; s++) begin : g_entry
		rob_entry #(.PRN_W(PRN_W)) entry_i (
			.clock           (clock),
			.rst_n           (rst_n),
			.load1           (load1_vec[s]),
			.load2           (load2_vec[s]),
			.inst1_pc        (inst1_pc),
			.inst1_arn       (inst1_arn),
			.inst1_prn       (inst1_prn),
			.inst1_is_branch (inst1_is_branch),
			.inst2_pc        (inst2_pc),
			.inst2_arn       (inst2_arn),
			.inst2_prn       (inst2_prn),
			.inst2_is_branch (inst2_is_branch),
			.complete        (slot_complete[s]),
			.mispredict_in   (slot_mispredict[s]),
			.clear           (clear_vec[s]),
			.live            (entry_live[s]),
			.done            (entry_done[s]),
			.pc              (entry_pc[s]),
			.arn             (entry_arn[s]),
			.prn             (entry_prn[s]),
			.is_branch       (entry_is_branch[s]),
			.mispredict      (entry_mispredict[s])
		);
	end

	rob_commit #(.ROB_SIZE(ROB_SIZE), .PRN_W(PRN_W)) commit_i (
		.clock              (clock),
		.rst_n              (rst_n),
		.entry_live         (entry_live),
		.entry_done         (entry_done),
		.entry_mispredict   (entry_mispredict),
		.entry_is_branch    (entry_is_branch),
		.entry_pc           (entry_pc),
		.entry_arn          (entry_arn),
		.entry_prn          (entry_prn),
		.head               (head),
		.clear_vec          (clear_vec),
		.flush              (flush),
		.credit_return      (credit_return),
		.commit1_valid      (commit1_valid),
		.commit1_pc         (commit1_pc),
		.commit1_arn        (commit1_arn),
		.commit1_prn        (commit1_prn),
		.commit1_is_branch  (commit1_is_branch),
		.commit1_mispredict (commit1_mispredict),
		.commit2_valid      (commit2_valid),
		.commit2_pc         (commit2_pc),
		.commit2_arn        (commit2_arn),
		.commit2_prn        (commit2_prn),
		.commit2_is_branch  (commit2_is_branch),
		.commit2_mispredict (commit2_mispredict)
	);

	// tail pointer, snaps back to head when younger work is killed
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			tail <= '0;
		else if (flush)
			tail <= head;
		else
			tail <= tail + IDX_W'(alloc_count);
	end

	always_comb begin
		occupancy = '0;
		for (int i = 0; i < ROB_SIZE; i++)
			occupancy = occupancy + CNT_W'(entry_live[i]);
	end

	// the credit scheme must keep dispatch from overrunning live entries
	a_no_overflow: assert property (@(posedge clock) disable iff (!rst_n)
		(int'(occupancy) + int'(alloc_count)) <= ROB_SIZE);

endmodule

//--- hdl/rob_alloc_select.sv
/*
 * dispatch slot allocation at the tail
 * maps the two requests onto consecutive slots in program order,
 * returns their indices and the tail advance
 */
`timescale 1ns/1ps

module rob_alloc_select #(
	parameter  int ROB_SIZE = 16,
	localparam int IDX_W    = $clog2(ROB_SIZE)
) (
	input  logic [IDX_W-1:0]    tail,			// next free slot in program order
	input  logic                inst1_valid,
	input  logic                inst2_valid,
	output logic [ROB_SIZE-1:0] load1_vec,		// one-hot write enable, lane 1
	output logic [ROB_SIZE-1:0] load2_vec,		// one-hot write enable, lane 2
	output logic [IDX_W-1:0]    inst1_rob_idx,
	output logic [IDX_W-1:0]    inst2_rob_idx,
	output logic [1:0]          alloc_count		// entries taken this cycle
);

	logic [IDX_W-1:0] slot_first;	// tail itself
	logic [IDX_W-1:0] slot_second;	// the slot after tail

	assign slot_first  = tail;
	assign slot_second = tail + 1'b1;	// wraps since ROB_SIZE is a power of two

	// lane 1 always sits at the tail
	assign inst1_rob_idx = slot_first;

	// lane 2 moves up to the tail when lane 1 is empty
	assign inst2_rob_idx = inst1_valid ? slot_second : slot_first;

	assign alloc_count = {1'b0, inst1_valid} + {1'b0, inst2_valid};

	// index to one-hot decode for the entry array
	always_comb begin
		load1_vec = '0;
		load2_vec = '0;
		for (int i = 0; i < ROB_SIZE; i++) begin
			if (inst1_valid && (inst1_rob_idx == IDX_W'(i)))
				load1_vec[i] = 1'b1;
			if (inst2_valid && (inst2_rob_idx == IDX_W'(i)))
				load2_vec[i] = 1'b1;
		end
	end

endmodule

//--- hdl/rob_commit.sv
/*
 * in-order retirement for the reorder buffer
 * head pointer, two-wide commit, mispredict flush FSM
 * and the credit count returned to dispatch
 */
`timescale 1ns/1ps

module rob_commit #(
	parameter  int ROB_SIZE = 16,
	parameter  int PRN_W    = rob_pkg::PRN_W,
	localparam int IDX_W    = $clog2(ROB_SIZE),
	localparam int CNT_W    = $clog2(ROB_SIZE + 1)
) (
	input  logic                           clock,
	input  logic                           rst_n,
	// slot status and fields, one element per slot
	input  logic [ROB_SIZE-1:0]            entry_live,
	input  logic [ROB_SIZE-1:0]            entry_done,
	input  logic [ROB_SIZE-1:0]            entry_mispredict,
	input  logic [ROB_SIZE-1:0]            entry_is_branch,
	input  rob_pkg::pc_t  [ROB_SIZE-1:0]   entry_pc,
	input  rob_pkg::arn_t [ROB_SIZE-1:0]   entry_arn,
	input  logic [ROB_SIZE-1:0][PRN_W-1:0] entry_prn,
	output logic [IDX_W-1:0]               head,			// oldest slot
	output logic [ROB_SIZE-1:0]            clear_vec,		// slots freed at the next edge
	output logic                           flush,
	output logic [CNT_W-1:0]               credit_return,
	// commit records toward the retirement rename table
	output logic                           commit1_valid,
	output rob_pkg::pc_t                   commit1_pc,
	output rob_pkg::arn_t                  commit1_arn,
	output logic [PRN_W-1:0]               commit1_prn,
	output logic                           commit1_is_branch,
	output logic                           commit1_mispredict,
	output logic                           commit2_valid,
	output rob_pkg::pc_t                   commit2_pc,
	output rob_pkg::arn_t                  commit2_arn,
	output logic [PRN_W-1:0]               commit2_prn,
	output logic                           commit2_is_branch,
	output logic                           commit2_mispredict
);

	rob_pkg::commit_state_t state;
	logic [IDX_W-1:0] head_next;		// second oldest slot
	logic             head_redirect;	// head is a mispredicted branch
	logic             next_redirect;	// head_next is a mispredicted branch
	logic             take1;			// head retires this cycle
	logic             take2;			// head_next retires too
	logic [CNT_W-1:0] live_count;		// slots killed by a flush
	logic [CNT_W-1:0] commit_credit;	// registered with the commit records

	assign head_next     = head + 1'b1;
	assign head_redirect = entry_is_branch[head] & entry_mispredict[head];
	assign next_redirect = entry_is_branch[head_next] & entry_mispredict[head_next];
	assign flush         = (state == rob_pkg::cs_flush);

	assign take1 = !flush && entry_live[head] && entry_done[head];
	// a redirecting branch retires alone in either slot
	assign take2 = take1 && !head_redirect && !next_redirect &&
		entry_live[head_next] && entry_done[head_next];

	always_comb begin
		live_count = '0;
		for (int i = 0; i < ROB_SIZE; i++)
			live_count = live_count + CNT_W'(entry_live[i]);
	end

	always_comb begin
		clear_vec = '0;
		if (flush) begin
			clear_vec = entry_live;	// everything left is younger than the branch
		end else begin
			clear_vec[head]      = take1;
			clear_vec[head_next] = take2;
		end
	end

	// the branch credit and the flushed slots can land in the same cycle
	assign credit_return = commit_credit + (flush ? live_count : '0);

	// head, FSM and commit valids
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state         <= rob_pkg::cs_run;
			head          <= '0;
			commit_credit <= '0;
			commit1_valid <= 1'b0;
			commit2_valid <= 1'b0;
		end else begin
			commit1_valid <= take1;
			commit2_valid <= take2;
			commit_credit <= CNT_W'(take1) + CNT_W'(take2);
			head          <= head + IDX_W'(take1) + IDX_W'(take2);
			case (state)
				rob_pkg::cs_run:   if (take1 && head_redirect) state <= rob_pkg::cs_flush;
				rob_pkg::cs_flush: state <= rob_pkg::cs_run;	// tail follows head now
				default:           state <= rob_pkg::cs_run;
			endcase
		end
	end

	// commit record payload
	always_ff @(posedge clock) begin
		if (take1) begin
			commit1_pc         <= entry_pc[head];
			commit1_arn        <= entry_arn[head];
			commit1_prn        <= entry_prn[head];
			commit1_is_branch  <= entry_is_branch[head];
			commit1_mispredict <= head_redirect;
		end
		if (take2) begin
			commit2_pc         <= entry_pc[head_next];
			commit2_arn        <= entry_arn[head_next];
			commit2_prn        <= entry_prn[head_next];
			commit2_is_branch  <= entry_is_branch[head_next];
			commit2_mispredict <= next_redirect;
		end
	end

	// retirement is in order so lane 2 never commits without lane 1
	a_commit_order: assert property (@(posedge clock) disable iff (!rst_n)
		commit2_valid |-> commit1_valid);

endmodule

//--- hdl/rob_entry.sv
/*
 * one reorder buffer slot
 * holds pc, destinations and branch flag of a dispatched instruction
 * along with its live, done and mispredict status
 */
`timescale 1ns/1ps

module rob_entry #(
	parameter int PRN_W = rob_pkg::PRN_W
) (
	input  logic               clock,
	input  logic               rst_n,
	// dispatch lanes, at most one selects this slot
	input  logic               load1,
	input  logic               load2,
	input  rob_pkg::pc_t       inst1_pc,
	input  rob_pkg::arn_t      inst1_arn,
	input  logic [PRN_W-1:0]   inst1_prn,
	input  logic               inst1_is_branch,
	input  rob_pkg::pc_t       inst2_pc,
	input  rob_pkg::arn_t      inst2_arn,
	input  logic [PRN_W-1:0]   inst2_prn,
	input  logic               inst2_is_branch,
	// completion from the decoded fu reports
	input  logic               complete,
	input  logic               mispredict_in,	// branch outcome, only with complete
	input  logic               clear,			// commit or flush frees the slot
	output logic               live,			// slot holds an instruction in flight
	output logic               done,			// instruction has executed
	output rob_pkg::pc_t       pc,
	output rob_pkg::arn_t      arn,
	output logic [PRN_W-1:0]   prn,
	output logic               is_branch,
	output logic               mispredict
);

	logic load;		// either lane writes this slot

	assign load = load1 | load2;

	// status bits
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			live       <= 1'b0;
			done       <= 1'b0;
			mispredict <= 1'b0;
		end else if (load) begin
			live       <= 1'b1;	// fresh instruction, nothing executed yet
			done       <= 1'b0;
			mispredict <= 1'b0;
		end else begin
			if (clear)
				live <= 1'b0;
			if (complete) begin
				done       <= 1'b1;
				mispredict <= mispredict_in;
			end
		end
	end

	// instruction fields, lane 1 is the older one when both exist
	always_ff @(posedge clock) begin
		if (load1) begin
			pc        <= inst1_pc;
			arn       <= inst1_arn;
			prn       <= inst1_prn;
			is_branch <= inst1_is_branch;
		end else if (load2) begin
			pc        <= inst2_pc;
			arn       <= inst2_arn;
			prn       <= inst2_prn;
			is_branch <= inst2_is_branch;
		end
	end

	// the allocation selector never books one slot for both lanes
	a_single_load: assert property (@(posedge clock) disable iff (!rst_n)
		!(load1 && load2));

	// fu reports only name instructions that are in flight and not yet done
	a_complete_live: assert property (@(posedge clock) disable iff (!rst_n)
		complete |-> (live && !done));

endmodule

//--- hdl/rob_pkg.sv
/*
 * shared definitions for the two-wide reorder buffer
 * instruction address and register number types, fu count,
 * and the state encoding of the commit FSM
 */
package rob_pkg;

	// instruction address as sent by dispatch
	typedef logic [31:0] pc_t;

	typedef logic [4:0] arn_t;	// architectural register number

	// physical register number width
	// only a default, rob passes its own value down
	localparam int PRN_W = 6;

	// completion sources fixed by the core
	// mult1 mult2 add1 add2 mem1 mem2, in fu_done bit order
	localparam int NUM_FU = 6;

	// commit FSM
	// cs_run retires up to two entries per cycle
	// cs_flush is the single cycle that kills younger work after a mispredict
	typedef enum logic [0:0] {
		cs_run,
		cs_flush
	} commit_state_t;

endpackage

//--- run.sh
#!/bin/sh
# builds the reorder buffer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module rob_tb -o rob_sim

# the simulator exits non-zero on a failed check, the log decides
./obj_dir/rob_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- verification/rob_tb.sv
/*
 * trace driven testbench for the two-wide reorder buffer
 * dispatch credit model, index model and in-order commit checker
 */
`timescale 1ns/1ps

module rob_tb;

	localparam int ROB_SIZE = 16;
	localparam int PRN_W    = rob_pkg::PRN_W;
	localparam int IDX_W    = $clog2(ROB_SIZE);
	localparam int CNT_W    = $clog2(ROB_SIZE + 1);
	localparam int REC_W    = 39 + PRN_W;	// pc, arn, prn, branch, mispredict
	localparam int MAX_CMD  = 256;

	logic                                  clock;
	logic                                  rst_n;
	logic                                  inst1_valid, inst2_valid;
	rob_pkg::pc_t                          inst1_pc, inst2_pc;
	rob_pkg::arn_t                         inst1_arn, inst2_arn;
	logic [PRN_W-1:0]                      inst1_prn, inst2_prn;
	logic                                  inst1_is_branch, inst2_is_branch;
	logic [IDX_W-1:0]                      inst1_rob_idx, inst2_rob_idx;
	logic [rob_pkg::NUM_FU-1:0]            fu_done;
	logic [rob_pkg::NUM_FU-1:0][IDX_W-1:0] fu_rob_idx;
	logic [rob_pkg::NUM_FU-1:0]            fu_mispredict;
	logic                                  commit1_valid, commit2_valid;
	rob_pkg::pc_t                          commit1_pc, commit2_pc;
	rob_pkg::arn_t                         commit1_arn, commit2_arn;
	logic [PRN_W-1:0]                      commit1_prn, commit2_prn;
	logic                                  commit1_is_branch, commit2_is_branch;
	logic                                  commit1_mispredict, commit2_mispredict;
	logic                                  flush;
	logic [CNT_W-1:0]                      credit_return;

	int               credits;				// dispatch side credit counter
	int               live_cnt;				// instructions the model thinks are in flight
	int               model_head;
	int               model_tail;
	int               idx_of [0:63];		// trace instruction number to rob index
	logic [REC_W-1:0] exp_q [$];			// expected commit records, program order
	byte              kind [0:MAX_CMD-1];
	int               fld [0:MAX_CMD-1][0:11];
	int               n_cmd;
	bit               trace_loaded;

	rob #(.ROB_SIZE(ROB_SIZE), .PRN_W(PRN_W)) dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;	// 20 ns period
	end

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic match_commit(input string lane, input logic [REC_W-1:0] got);
		check({lane, " has an expected record"}, exp_q.size() > 0, 1);
		check({lane, " record"}, got, exp_q.pop_front());
	endtask

	// one cycle, waits for the falling edge and checks what the last rising edge produced
	task automatic advance();
		int n;
		@(negedge clock);
		n = 0;
		if (commit1_valid) begin
			match_commit("commit1", {commit1_pc, commit1_arn, commit1_prn,
				commit1_is_branch, commit1_mispredict});
			n++;
		end
		if (commit2_valid) begin
			check("commit2 without commit1", commit1_valid, 1);
			check("mispredict retired in lane 2", commit2_mispredict, 0);
			match_commit("commit2", {commit2_pc, commit2_arn, commit2_prn,
				commit2_is_branch, commit2_mispredict});
			n++;
		end
		if (commit1_valid && commit1_mispredict) begin
			check("mispredict commits alone", commit2_valid, 0);
			check("flush beside mispredict commit", flush, 1);
		end
		live_cnt   = live_cnt - n;
		model_head = (model_head + n) % ROB_SIZE;
		if (flush) begin
			check("flush only after a mispredict", commit1_valid && commit1_mispredict, 1);
			check("credit_return on flush", credit_return, n + live_cnt);	// branch plus killed
			live_cnt   = 0;
			model_tail = model_head;
		end else begin
			check("credit_return", credit_return, n);
		end
		credits = credits + int'(credit_return);
	endtask

	task automatic dispatch(input int c);
		int cnt;
		cnt = fld[c][0] + fld[c][1];
		while (credits < cnt || flush)	// wait for credits and for the flush cycle to pass
			advance();
		inst1_valid     = fld[c][0][0];
		inst1_pc        = fld[c][3];
		inst1_arn       = fld[c][4][4:0];
		inst1_prn       = fld[c][5][PRN_W-1:0];
		inst1_is_branch = fld[c][6][0];
		inst2_valid     = fld[c][1][0];
		inst2_pc        = fld[c][8];
		inst2_arn       = fld[c][9][4:0];
		inst2_prn       = fld[c][10][PRN_W-1:0];
		inst2_is_branch = fld[c][11][0];
		#1;	// index answer is combinational
		if (fld[c][0] != 0) begin
			check("inst1_rob_idx", inst1_rob_idx, model_tail);
			idx_of[fld[c][2]] = model_tail;
			model_tail = (model_tail + 1) % ROB_SIZE;
		end
		if (fld[c][1] != 0) begin
			check("inst2_rob_idx", inst2_rob_idx, model_tail);	// tail when lane 1 idle
			idx_of[fld[c][7]] = model_tail;
			model_tail = (model_tail + 1) % ROB_SIZE;
		end
		credits  = credits - cnt;
		live_cnt = live_cnt + cnt;
		advance();
		inst1_valid = 1'b0;
		inst2_valid = 1'b0;
	endtask

	task automatic complete(input int unit, input int inst, input bit mis);
		fu_done[unit]       = 1'b1;
		fu_rob_idx[unit]    = IDX_W'(idx_of[inst]);
		fu_mispredict[unit] = mis;
		advance();
		fu_done       = '0;
		fu_mispredict = '0;
	endtask

	task automatic load_trace();
		int               fd;
		int               r;
		int               v [0:11];
		byte              k;
		string            line;
		fd = $fopen("verification/rob_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file verification/rob_trace.txt");
			$display("TESTS FAILED");
			$fatal(1, "no trace");
		end
		n_cmd = 0;
		while (!$feof(fd)) begin
			line = "";
			r = $fgets(line, fd);
			if (r == 0 || line.len() < 2 || line[0] == "#")
				continue;
			k = line[0];
			foreach (v[i])
				v[i] = 0;
			case (k)
				"D": r = $sscanf(line, "D %d %d %d %h %d %d %d %d %h %d %d %d", v[0], v[1],
					v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
				"C": r = $sscanf(line, "C %d %d %d", v[0], v[1], v[2]);
				"I": r = $sscanf(line, "I %d", v[0]);
				"X": begin
					r = $sscanf(line, "X %h %d %d %d %d", v[0], v[1], v[2], v[3], v[4]);
					exp_q.push_back({v[0][31:0], v[1][4:0], v[2][PRN_W-1:0], v[3][0], v[4][0]});
				end
				default: ;
			endcase
			kind[n_cmd] = k;
			for (int i = 0; i < 12; i++)
				fld[n_cmd][i] = v[i];
			n_cmd++;
		end
		$fclose(fd);
	endtask

	// watchdog scaled by trace length
	initial begin
		wait (trace_loaded);
		repeat (n_cmd * 40 + 200) @(posedge clock);
		$display("watchdog expired: the trace did not finish in time");
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		int n_idle;
		void'($urandom(32'h473e_bc73));
		rst_n         = 1'b0;
		inst1_valid   = 1'b0;
		inst2_valid   = 1'b0;
		inst1_pc      = '0;
		inst2_pc      = '0;
		inst1_arn     = '0;
		inst2_arn     = '0;
		inst1_prn     = '0;
		inst2_prn     = '0;
		inst1_is_branch = 1'b0;
		inst2_is_branch = 1'b0;
		fu_done       = '0;
		fu_rob_idx    = '0;
		fu_mispredict = '0;
		credits       = ROB_SIZE;
		live_cnt      = 0;
		model_head    = 0;
		model_tail    = 0;
		trace_loaded  = 1'b0;
		load_trace();
		trace_loaded = 1'b1;

		repeat (16) advance();	// reset held 16 cycles
		rst_n = 1'b1;
		repeat (6) begin	// quiet after reset
			advance();
			check("idle commit1_valid", commit1_valid, 0);
			check("idle commit2_valid", commit2_valid, 0);
			check("idle flush", flush, 0);
			check("idle credit_return", credit_return, 0);
		end

		for (int c = 0; c < n_cmd; c++) begin
			case (kind[c])
				"D": dispatch(c);
				"C": complete(fld[c][0], fld[c][1], fld[c][2][0]);
				"I": repeat (fld[c][0]) advance();
				default: ;
			endcase
			if (kind[c] != "X") begin
				n_idle = $urandom % 3;	// random gaps between commands
				repeat (n_idle) advance();
			end
		end

		// drain until every expected record has retired
		while (exp_q.size() > 0 || credits < ROB_SIZE)
			advance();
		check("credits after trace", credits, ROB_SIZE);
		check("model live count", live_cnt, 0);

		// a mispredicted branch one slot behind a ready head still retires alone
		fld[MAX_CMD-2] = '{1, 1, 60, 32'h5000, 1, 2, 0, 61, 32'h5004, 2, 3, 1};
		fld[MAX_CMD-3] = '{1, 0, 62, 32'h5008, 3, 4, 0, 0, 0, 0, 0, 0};
		exp_q.push_back({32'h5000, 5'd1, PRN_W'(2), 1'b0, 1'b0});
		exp_q.push_back({32'h5004, 5'd2, PRN_W'(3), 1'b1, 1'b1});
		dispatch(MAX_CMD - 2);
		dispatch(MAX_CMD - 3);
		complete(0, 62, 1'b0);	// younger instruction finishes first and must be flushed
		complete(1, 61, 1'b1);
		complete(2, 60, 1'b0);
		while (exp_q.size() > 0 || credits < ROB_SIZE)
			advance();
		check("credits after late mispredict", credits, ROB_SIZE);

		// a full ROB worth of dispatches fits again
		for (int i = 0; i < 8; i++) begin
			fld[MAX_CMD-1][0] = 1;
			fld[MAX_CMD-1][1] = 1;
			fld[MAX_CMD-1][2] = 40 + 2 * i;
			fld[MAX_CMD-1][3] = 32'h4000 + 8 * i;
			fld[MAX_CMD-1][7] = 41 + 2 * i;
			fld[MAX_CMD-1][8] = 32'h4004 + 8 * i;
			dispatch(MAX_CMD - 1);
		end
		check("credits after refill", credits, 0);
		repeat (2) advance();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- verification/rob_trace.txt
# D v1 v2 | n1 pc1 arn1 prn1 br1 | n2 pc2 arn2 prn2 br2   C unit inst mispredict   I cycles
# X pc arn prn is_branch mispredict, expected commit records in program order
D 1 1 0 00001000 1 10 0 1 00001004 2 11 0
C 2 0 0
C 3 1 0
X 00001000 1 10 0 0
X 00001004 2 11 0 0
D 1 1 2 00001008 3 12 0 3 0000100c 4 13 0
D 1 0 4 00001010 5 14 0 0 00000000 0 0 0
C 4 4 0
C 0 3 0
C 1 2 0
X 00001008 3 12 0 0
X 0000100c 4 13 0 0
X 00001010 5 14 0 0
D 1 1 5 00001014 6 15 0 6 00001018 0 16 1
D 1 1 7 0000101c 7 17 0 8 00001020 8 18 0
C 2 5 0
C 5 7 0
C 3 6 1
I 3
X 00001014 6 15 0 0
X 00001018 0 16 1 1
D 1 1 9 00002000 1 20 0 10 00002004 2 21 0
D 1 1 11 00002008 3 22 0 12 0000200c 4 23 0
D 0 1 0 00000000 0 0 0 13 00002010 5 24 0
D 1 1 14 00002014 6 25 0 15 00002018 7 26 0
D 1 0 16 0000201c 8 27 0 0 00000000 0 0 0
D 1 1 17 00002020 9 28 0 18 00002024 10 29 0
C 0 18 0
C 1 10 0
C 2 9 0
C 3 12 0
C 4 11 0
C 5 14 0
C 0 13 0
C 1 16 0
C 2 15 0
C 3 17 0
X 00002000 1 20 0 0
X 00002004 2 21 0 0
X 00002008 3 22 0 0
X 0000200c 4 23 0 0
X 00002010 5 24 0 0
X 00002014 6 25 0 0
X 00002018 7 26 0 0
X 0000201c 8 27 0 0
X 00002020 9 28 0 0
X 00002024 10 29 0 0
D 1 1 19 00003000 11 30 1 20 00003004 12 31 0
C 4 20 0
C 5 19 0
X 00003000 11 30 1 0
X 00003004 12 31 0 0
I 4
